/* common/uart_pkg.sv */
// UART echo shared definitions

package uart_pkg;

	////////////////////////////////////////
	// Frame and buffer constants
	////////////////////////////////////////

	// Data bits per 8N1 frame
	localparam int DATA_BITS      = 8;
	// Buffer address width, 16 entries
	localparam int FIFO_ADDR_BITS = 4;
	// Oversampling ticks per bit
	localparam int OVERSAMPLE     = 16;
	// Clocks per oversampling tick
	localparam int BAUD_DIV       = 4;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// One data byte on the serial line
	typedef logic [DATA_BITS-1:0] uart_byte_t;

	// Tick position inside one bit
	typedef logic [$clog2(OVERSAMPLE)-1:0] tick_count_t;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	// Top level status flags
	typedef struct packed {
		logic fifo_full;
		logic fifo_empty;
		logic framing_error;
	} uart_status_t;

endpackage

/* uart/baud_gen.sv */
// Oversampling tick divider
`timescale 1ns/1ps

module baud_gen
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// Clocks elapsed in the current tick period
	logic [$clog2(uart_pkg::BAUD_DIV)-1:0] div_cnt;

	// Wraps on the terminal count
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Terminal count gives the one-cycle tick
	assign tick = (int'(div_cnt) == uart_pkg::BAUD_DIV - 1);

endmodule

/* uart/uart_rx.sv */
// UART 8N1 receiver
`timescale 1ns/1ps

module uart_rx
(
	input  logic                clk,
	input  logic                reset,
	input  logic                tick,
	input  logic                rx,
	output logic                rx_done,
	output uart_pkg::uart_byte_t rx_byte,
	output logic                framing_error
);

	// Two-flop synchroniser on the async line
	logic rx_meta;
	logic rx_sync;

	uart_pkg::rx_state_t   state;
	uart_pkg::tick_count_t tick_cnt;
	logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_cnt;

	// Last tick of a full bit, and mid-bit for the start check
	logic bit_end;
	logic mid_start;

	assign bit_end   = tick && (tick_cnt == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE - 1));
	assign mid_start = tick && (tick_cnt == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE / 2 - 1));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state         <= uart_pkg::RX_IDLE;
			tick_cnt      <= '0;
			bit_cnt       <= '0;
			rx_done       <= 1'b0;
			framing_error <= 1'b0;
		end
		else
		begin
			// Done is a single-cycle strobe
			rx_done <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE:
					if (!rx_sync)
					begin
						state    <= uart_pkg::RX_START;
						tick_cnt <= '0;
					end
				uart_pkg::RX_START:
					if (mid_start)
					begin
						// Line back high at mid-bit is a glitch
						state    <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				uart_pkg::RX_DATA:
					if (bit_end)
					begin
						tick_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (int'(bit_cnt) == uart_pkg::DATA_BITS - 1)
							state <= uart_pkg::RX_STOP;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				uart_pkg::RX_STOP:
					if (bit_end)
					begin
						state <= uart_pkg::RX_IDLE;
						// Low stop bit drops the byte, flag stays until reset
						if (rx_sync)
							rx_done <= 1'b1;
						else
							framing_error <= 1'b1;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first, shift in at the top
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::RX_DATA && bit_end)
			rx_byte <= {rx_sync, rx_byte[uart_pkg::DATA_BITS-1:1]};
	end

endmodule

/* uart/uart_tx.sv */
// UART 8N1 transmitter
`timescale 1ns/1ps

module uart_tx
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 tx_pause,
	input  logic                 fifo_empty,
	input  uart_pkg::uart_byte_t fifo_data,
	output logic                 fifo_rd,
	output logic                 tx
);

	uart_pkg::tx_state_t   state;
	uart_pkg::tick_count_t tick_cnt;
	logic [$clog2(uart_pkg::DATA_BITS)-1:0] bit_cnt;

	// Byte being serialised
	uart_pkg::uart_byte_t shift_reg;

	logic bit_end;

	assign bit_end = tick && (tick_cnt == uart_pkg::tick_count_t'(uart_pkg::OVERSAMPLE - 1));

	// Pop only from idle, so rd lasts one cycle and never hits an empty buffer
	assign fifo_rd = (state == uart_pkg::TX_IDLE) && !fifo_empty && !tx_pause;

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state    <= uart_pkg::TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx       <= 1'b1;
		end
		else
		begin
			case (state)
				uart_pkg::TX_IDLE:
					if (fifo_rd)
					begin
						state    <= uart_pkg::TX_START;
						tick_cnt <= '0;
						tx       <= 1'b0;
					end
				uart_pkg::TX_START:
					if (bit_end)
					begin
						state    <= uart_pkg::TX_DATA;
						tick_cnt <= '0;
						bit_cnt  <= '0;
						tx       <= shift_reg[0];
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				uart_pkg::TX_DATA:
					if (bit_end)
					begin
						tick_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						// After the last data bit drive the stop level
						if (int'(bit_cnt) == uart_pkg::DATA_BITS - 1)
						begin
							state <= uart_pkg::TX_STOP;
							tx    <= 1'b1;
						end
						else
							tx <= shift_reg[1];
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				uart_pkg::TX_STOP:
					if (bit_end)
						state <= uart_pkg::TX_IDLE;
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				default:
					state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// Latch on pop, move right once per data bit
	always_ff @(posedge clk)
	begin
		if (fifo_rd)
			shift_reg <= fifo_data;
		else if (state == uart_pkg::TX_DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

endmodule

/* logic/fifo.sv */
// Register-file FIFO
`timescale 1ns/1ps

module fifo
#(
	parameter int B = 8,
	parameter int W = 4
)
(
	input  logic         clk,
	input  logic         reset,
	input  logic         rd,
	input  logic         wr,
	input  logic [B-1:0] w_data,
	output logic         empty,
	output logic         full,
	output logic [B-1:0] r_data
);

	// Storage, 2**W entries
	logic [B-1:0] array_reg [2**W];

	logic [W-1:0] w_ptr_reg, w_ptr_next, w_ptr_succ;
	logic [W-1:0] r_ptr_reg, r_ptr_next, r_ptr_succ;
	logic         full_reg, empty_reg, full_next, empty_next;
	logic         wr_en;

	// Writes blocked while full
	assign wr_en = wr & ~full_reg;

	always_ff @(posedge clk)
	begin
		if (wr_en)
			array_reg[w_ptr_reg] <= w_data;
	end

	// Head of queue, read without a register stage
	assign r_data = array_reg[r_ptr_reg];

	////////////////////////////////////////
	// Pointers and flags
	////////////////////////////////////////

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			w_ptr_reg <= '0;
			r_ptr_reg <= '0;
			full_reg  <= 1'b0;
			empty_reg <= 1'b1;
		end
		else
		begin
			w_ptr_reg <= w_ptr_next;
			r_ptr_reg <= r_ptr_next;
			full_reg  <= full_next;
			empty_reg <= empty_next;
		end
	end

	always_comb
	begin
		w_ptr_succ = w_ptr_reg + 1'b1;
		r_ptr_succ = r_ptr_reg + 1'b1;
		w_ptr_next = w_ptr_reg;
		r_ptr_next = r_ptr_reg;
		full_next  = full_reg;
		empty_next = empty_reg;
		case ({wr, rd})
			// Read only
			2'b01:
				if (~empty_reg)
				begin
					r_ptr_next = r_ptr_succ;
					full_next  = 1'b0;
					if (r_ptr_succ == w_ptr_reg)
						empty_next = 1'b1;
				end
			// Write only
			2'b10:
				if (~full_reg)
				begin
					w_ptr_next = w_ptr_succ;
					empty_next = 1'b0;
					if (w_ptr_succ == r_ptr_reg)
						full_next = 1'b1;
				end
			// Both, occupancy unchanged
			2'b11:
			begin
				w_ptr_next = w_ptr_succ;
				r_ptr_next = r_ptr_succ;
			end
			default:
			begin
			end
		endcase
	end

	assign full  = full_reg;
	assign empty = empty_reg;

endmodule

/* logic/uart_echo.sv */
// UART echo top level
`timescale 1ns/1ps

module uart_echo
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rx,
	input  logic                   tx_pause,
	output logic                   tx,
	output uart_pkg::uart_status_t status
);

	logic                 tick;
	logic                 rx_done;
	uart_pkg::uart_byte_t rx_byte;
	logic                 framing_error;
	logic                 fifo_rd;
	logic                 fifo_empty;
	logic                 fifo_full;
	uart_pkg::uart_byte_t fifo_data;

	// Shared bit timing for both directions
	baud_gen u_baud_gen (.clk(clk), .reset(reset), .tick(tick));

	uart_rx u_uart_rx
	(
		.clk(clk), .reset(reset), .tick(tick), .rx(rx),
		.rx_done(rx_done), .rx_byte(rx_byte), .framing_error(framing_error)
	);

	// Received bytes queue here until the transmitter pops them
	fifo #(.B(uart_pkg::DATA_BITS), .W(uart_pkg::FIFO_ADDR_BITS)) u_fifo
	(
		.clk(clk), .reset(reset), .rd(fifo_rd), .wr(rx_done), .w_data(rx_byte),
		.empty(fifo_empty), .full(fifo_full), .r_data(fifo_data)
	);

	uart_tx u_uart_tx
	(
		.clk(clk), .reset(reset), .tick(tick), .tx_pause(tx_pause),
		.fifo_empty(fifo_empty), .fifo_data(fifo_data), .fifo_rd(fifo_rd), .tx(tx)
	);

	// Status bundle
	assign status.fifo_full     = fifo_full;
	assign status.fifo_empty    = fifo_empty;
	assign status.framing_error = framing_error;

endmodule

/* verification/uart_echo_checker.sv */
// UART echo scoreboard
`timescale 1ns/1ps

module uart_echo_checker
(
	input logic                   clk,
	input logic                   reset,
	input logic                   tx,
	input uart_pkg::uart_status_t status
);

	// Clocks per serial bit
	localparam int BIT_CLKS = uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV;

	// Expected echo, oldest first
	uart_pkg::uart_byte_t exp_bytes[$];
	string                exp_names[$];

	int mismatch_count = 0;
	int other_count    = 0;

	////////////////////////////////////////
	// Calls from the testbench
	////////////////////////////////////////

	function automatic void expect_byte(input string name, input uart_pkg::uart_byte_t data);
		exp_names.push_back(name);
		exp_bytes.push_back(data);
	endfunction

	// Bytes still owed on tx
	function automatic int pending();
		return exp_bytes.size();
	endfunction

	// Only the bits set in mask are compared
	function automatic void check_status(input string name,
		input uart_pkg::uart_status_t exp_status, input uart_pkg::uart_status_t mask);
		logic [2:0] want;
		logic [2:0] got;
		want = exp_status & mask;
		got  = status & mask;
		if (got !== want)
		begin
			$display("MISMATCH %s status (full empty ferr) expected %b actual %b",
				name, want, got);
			mismatch_count++;
		end
	endfunction

	function automatic void check_line_idle(input string name);
		if (tx !== 1'b1)
		begin
			$display("ERROR: tx line is not idle high at %s", name);
			other_count++;
		end
	endfunction

	////////////////////////////////////////
	// tx frame decoder
	////////////////////////////////////////

	initial
	begin
		uart_pkg::uart_byte_t data;
		string                name;
		// Decode only once reset is released
		wait (reset === 1'b0);
		forever
		begin
			@(negedge tx);
			// Mid start bit
			repeat (BIT_CLKS / 2) @(negedge clk);
			if (tx !== 1'b0)
			begin
				$display("ERROR: start bit on tx was not low at mid-bit");
				other_count++;
			end
			// LSB first, one sample per bit centre
			for (int i = 0; i < uart_pkg::DATA_BITS; i++)
			begin
				repeat (BIT_CLKS) @(negedge clk);
				data[i] = tx;
			end
			repeat (BIT_CLKS) @(negedge clk);
			if (tx !== 1'b1)
			begin
				$display("ERROR: stop bit on tx was low for byte %h", data);
				other_count++;
			end
			if (exp_bytes.size() == 0)
			begin
				$display("ERROR: tx sent byte %h that was never expected", data);
				other_count++;
			end
			else
			begin
				name = exp_names.pop_front();
				if (data !== exp_bytes[0])
				begin
					$display("MISMATCH %s echo byte expected %h actual %h",
						name, exp_bytes[0], data);
					mismatch_count++;
				end
				exp_bytes.pop_front();
			end
		end
	end

endmodule

/* verification/uart_echo_props.sv */
// Buffer and transmitter assertions
`timescale 1ns/1ps

module uart_echo_props
(
	input logic clk,
	input logic reset,
	input logic fifo_full,
	input logic fifo_empty,
	input logic fifo_rd,
	input logic tx_idle,
	input logic tx
);

	// Flags exclusive for any nonzero depth
	a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(fifo_full && fifo_empty))
		else $error("fifo full and empty are high together");

	// Pop only with data present
	a_rd_not_empty: assert property (@(posedge clk) disable iff (reset)
		fifo_rd |-> !fifo_empty)
		else $error("fifo read strobe while the fifo is empty");

	// One pop per frame
	a_rd_pulse: assert property (@(posedge clk) disable iff (reset)
		fifo_rd |=> !fifo_rd)
		else $error("fifo read strobe held for more than one cycle");

	// Line rests high for every idle cycle of the transmitter
	a_idle_tx_high: assert property (@(posedge clk) disable iff (reset)
		tx_idle |-> tx)
		else $error("tx low while the transmitter is idle");

endmodule

// Attached where the buffer and the transmitter meet
bind uart_echo uart_echo_props props
(
	.clk(clk), .reset(reset), .fifo_full(fifo_full), .fifo_empty(fifo_empty),
	.fifo_rd(fifo_rd), .tx_idle(u_uart_tx.state == uart_pkg::TX_IDLE), .tx(tx)
);

/* verification/uart_echo_tb.sv */
// UART echo testbench
`timescale 1ns/1ps

module uart_echo_tb;

	// Serial timing from the package constants
	localparam int BIT_CLKS   = uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV;
	localparam int FRAME_CLKS = BIT_CLKS * (uart_pkg::DATA_BITS + 2);
	localparam int FIFO_DEPTH = 2 ** uart_pkg::FIFO_ADDR_BITS;
	localparam string VECTOR_FILE = "verification/uart_echo_vectors.txt";

	logic                   clk;
	logic                   reset;
	logic                   rx;
	logic                   tx_pause;
	logic                   tx;
	uart_pkg::uart_status_t status;

	// Vector columns
	uart_pkg::uart_byte_t vec_byte[$];
	logic                 vec_bad[$];
	logic                 vec_pause[$];
	logic                 vec_no_gap[$];

	logic [31:0] rng_state;
	int          cycles;
	int          cycle_limit;
	int          tb_errors;

	uart_echo dut
	(
		.clk(clk), .reset(reset), .rx(rx), .tx_pause(tx_pause),
		.tx(tx), .status(status)
	);

	uart_echo_checker chk (.clk(clk), .reset(reset), .tx(tx), .status(status));

	// 8 ns period
	always #4 clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic read_vectors;
		int    fd;
		int    n;
		int    b;
		int    bad;
		int    pause;
		int    no_gap;
		string line;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
		begin
			$display("ERROR: cannot open vector file %s", VECTOR_FILE);
			tb_errors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			// Skip comment lines
			if (line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%h %d %d %d", b, bad, pause, no_gap);
			if (n == 4)
			begin
				vec_byte.push_back(uart_pkg::uart_byte_t'(b));
				vec_bad.push_back(bad != 0);
				vec_pause.push_back(pause != 0);
				vec_no_gap.push_back(no_gap != 0);
			end
		end
		$fclose(fd);
	endtask

	// Entered and left on a falling edge
	task automatic hold_level(input logic level, input int clks);
		rx = level;
		repeat (clks) @(negedge clk);
	endtask

	task automatic send_frame(input uart_pkg::uart_byte_t data, input logic bad_stop);
		hold_level(1'b0, BIT_CLKS);
		for (int i = 0; i < uart_pkg::DATA_BITS; i++)
			hold_level(data[i], BIT_CLKS);
		// Bad stop released early, trailing low then reads as a glitch
		if (bad_stop)
		begin
			hold_level(1'b0, BIT_CLKS * 3 / 4);
			hold_level(1'b1, BIT_CLKS / 4);
		end
		else
			hold_level(1'b1, BIT_CLKS);
	endtask

	task automatic wait_fifo_empty;
		while (!status.fifo_empty)
			@(negedge clk);
	endtask

	////////////////////////////////////////
	// Vector run
	////////////////////////////////////////

	task automatic run_vectors;
		uart_pkg::uart_status_t exp_status;
		uart_pkg::uart_status_t mask;
		string                  name;
		int                     paused_good;
		int                     gap;
		paused_good = 0;
		exp_status.fifo_full     = 1'b0;
		exp_status.fifo_empty    = 1'b1;
		exp_status.framing_error = 1'b0;
		mask = '1;
		repeat (BIT_CLKS) @(negedge clk);
		chk.check_status("reset", exp_status, mask);
		chk.check_line_idle("reset");
		for (int i = 0; i < vec_byte.size(); i++)
		begin
			name = $sformatf("vector %0d", i);
			// Pause section opens on an empty buffer
			if (vec_pause[i] && !tx_pause)
			begin
				wait_fifo_empty();
				paused_good = 0;
			end
			else if (!vec_pause[i] && tx_pause)
			begin
				tx_pause = 1'b0;
				wait_fifo_empty();
				exp_status.fifo_full  = 1'b0;
				exp_status.fifo_empty = 1'b1;
				chk.check_status({name, " pause release"}, exp_status, '1);
			end
			tx_pause = vec_pause[i];
			// Bad frames dropped, paused overflow past the depth lost
			if (!vec_bad[i] && (!vec_pause[i] || paused_good < FIFO_DEPTH))
				chk.expect_byte(name, vec_byte[i]);
			if (!vec_bad[i] && vec_pause[i])
				paused_good++;
			if (vec_bad[i])
				exp_status.framing_error = 1'b1;
			send_frame(vec_byte[i], vec_bad[i]);
			// Occupancy known only while paused
			if (vec_pause[i])
			begin
				exp_status.fifo_full  = (paused_good >= FIFO_DEPTH);
				exp_status.fifo_empty = (paused_good == 0);
				mask = '1;
			end
			else
			begin
				mask = '0;
				mask.framing_error = 1'b1;
			end
			chk.check_status(name, exp_status, mask);
			if (!vec_no_gap[i])
			begin
				rng_state = xorshift(rng_state);
				gap = int'(rng_state[5:0]);
				repeat (gap) @(negedge clk);
			end
		end
		// Drain and let the last stop bit finish
		tx_pause = 1'b0;
		while (chk.pending() != 0 || !status.fifo_empty)
			@(negedge clk);
		repeat (BIT_CLKS) @(negedge clk);
		exp_status.fifo_full  = 1'b0;
		exp_status.fifo_empty = 1'b1;
		chk.check_status("end of run", exp_status, '1);
		chk.check_line_idle("end of run");
	endtask

	task automatic report_and_finish;
		int total;
		total = chk.mismatch_count + chk.other_count + tb_errors;
		$display("Error counts: %0d mismatch, %0d checker, %0d testbench, %0d total",
			chk.mismatch_count, chk.other_count, tb_errors, total);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////

	initial
	begin
		clk         = 1'b0;
		reset       = 1'b1;
		rx          = 1'b1;
		tx_pause    = 1'b0;
		rng_state   = 32'd29;
		cycles      = 0;
		cycle_limit = 0;
		tb_errors   = 0;
		read_vectors();
		// Three frame times per vector plus drain margin
		cycle_limit = vec_byte.size() * FRAME_CLKS * 3 + 20 * FRAME_CLKS;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		if (vec_byte.size() == 0)
		begin
			$display("ERROR: no stimulus lines were read from %s", VECTOR_FILE);
			tb_errors++;
		end
		else
			run_vectors();
		report_and_finish();
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("ERROR: timeout, run still busy after %0d cycles", cycle_limit);
			tb_errors++;
			report_and_finish();
		end
	end

endmodule

/* verification/uart_echo_vectors.txt */
# Columns: data byte (hex), bad stop bit, tx_pause level, no idle gap after the frame
# One line per 8N1 frame, sent in file order
55 0 0 0
a3 0 0 0
00 0 0 0
ff 0 0 0
3c 1 0 0
7e 0 0 0
5a 0 0 1
c3 0 0 1
96 0 0 1
0f 0 0 0
10 0 1 0
11 0 1 0
12 0 1 0
13 0 1 0
14 0 1 0
15 0 1 0
16 0 1 0
17 0 1 0
18 0 1 0
19 0 1 0
1a 0 1 0
1b 0 1 0
1c 0 1 0
1d 0 1 0
1e 0 1 0
1f 0 1 0
20 0 1 0
21 0 1 0
e1 0 0 0
1e 0 0 0

/* build.f */
common/uart_pkg.sv
uart/baud_gen.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/fifo.sv
logic/uart_echo.sv
verification/uart_echo_checker.sv
verification/uart_echo_props.sv
verification/uart_echo_tb.sv

/* Makefile */
# Verilator flow for the UART echo testbench
VERILATOR ?= verilator
TOP       ?= uart_echo_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= SIMULATION FAILED
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
